// ==== files.f ====
source/spram_pkg.sv
source/ram_macro.sv
source/spram.sv
source/mem_req_stage.sv
source/mem_rsp_stage.sv
source/spram_subsys.sv
verification/spram_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: spram_subsys

sources:
  # design, in compile order
  - files:
      - source/spram_pkg.sv
      - source/ram_macro.sv
      - source/spram.sv
      - source/mem_req_stage.sv
      - source/mem_rsp_stage.sv
      - source/spram_subsys.sv

  # testbench, top module spram_subsys_tb
  - target: test
    files:
      - verification/spram_subsys_tb.sv

// ==== verification/spram_subsys_tb.sv ====
// table-driven testbench for spram_subsys at its default macro geometry
// expected read data is written into the table by hand; reads only hit written addresses
`timescale 1ns/10ps
`default_nettype none

module spram_subsys_tb;

    import spram_pkg::*;

    localparam int RST_CYCLES = 5;
    localparam int LATENCY    = 3;   // strobe cycle to response cycle
    localparam int MARGIN     = 20;
    localparam logic [DATA_W-1:0] FULL = '1;

    // one stimulus row
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] mask;
        logic [DATA_W-1:0] wdata;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] exp;   // expected read data
        logic [3:0]        gap;   // idle cycles after this row
    } entry_t;

    // one outstanding read
    typedef struct packed {
        int                entry;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] rdata;
        int                due;   // cycle the response must show up
    } pending_t;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    mem_req_t req;
    logic     rsp_valid;
    mem_rsp_t rsp;

    entry_t   stim[$];
    pending_t exp_q[$];

    int cycle_cnt   = 0;
    int cycle_limit = 1000;  // recomputed from the table at time 0
    int read_cnt    = 0;
    int test_cnt    = 0;
    int pass_cnt    = 0;
    int error_cnt   = 0;

    spram_subsys dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d reads never answered",
                     cycle_cnt, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    task automatic add_entry(input logic write, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] mask, input logic [DATA_W-1:0] wdata,
                             input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] exp,
                             input int gap);
        entry_t e;
        e = '{write, addr, mask, wdata, tag, exp, gap[3:0]};
        stim.push_back(e);
        if (!write) begin
            read_cnt++;
        end
    endtask

    // 1 = write, 0 = read; mask and wdata unused on reads
    task automatic load_table();
        add_entry(1, 10'h005, FULL, 64'h1111_2222_3333_4444, 4'h0, 64'h0, 0);  // bank 0
        add_entry(1, 10'h105, FULL, 64'h5555_6666_7777_8888, 4'h0, 64'h0, 0);  // bank 1
        add_entry(1, 10'h205, FULL, 64'h9999_aaaa_bbbb_cccc, 4'h0, 64'h0, 0);  // bank 2
        add_entry(1, 10'h305, FULL, 64'hdddd_eeee_ffff_0000, 4'h0, 64'h0, 3);  // bank 3
        add_entry(1, 10'h010, FULL, 64'h0123_4567_89ab_cdef, 4'h0, 64'h0, 0);
        add_entry(0, 10'h010, 64'h0, 64'h0, 4'h1, 64'h0123_4567_89ab_cdef, 2);
        add_entry(1, 10'h020, FULL, 64'haaaa_aaaa_5555_5555, 4'h0, 64'h0, 0);
        add_entry(1, 10'h020, 64'hffff_ffff_0000_0000, 64'h1234_5678_ffff_ffff,
                  4'h0, 64'h0, 0);  // upper column only
        add_entry(0, 10'h020, 64'h0, 64'h0, 4'h2, 64'h1234_5678_5555_5555, 0);
        add_entry(1, 10'h020, 64'h0000_0000_ffff_ffff, 64'h0000_0000_9abc_def0,
                  4'h0, 64'h0, 0);  // lower column only
        add_entry(0, 10'h020, 64'h0, 64'h0, 4'h3, 64'h1234_5678_9abc_def0, 1);
        add_entry(1, 10'h020, 64'h00ff_00ff_f0f0_0f0f, 64'h0,
                  4'h0, 64'h0, 0);  // bit-level clear in both columns
        add_entry(0, 10'h020, 64'h0, 64'h0, 4'h4, 64'h1200_5600_0a0c_d0f0, 2);
        add_entry(0, 10'h005, 64'h0, 64'h0, 4'h5, 64'h1111_2222_3333_4444, 0);
        add_entry(0, 10'h205, 64'h0, 64'h0, 4'h6, 64'h9999_aaaa_bbbb_cccc, 0);
        add_entry(0, 10'h105, 64'h0, 64'h0, 4'h7, 64'h5555_6666_7777_8888, 0);
        add_entry(0, 10'h305, 64'h0, 64'h0, 4'h8, 64'hdddd_eeee_ffff_0000, 0);
        add_entry(0, 10'h005, 64'h0, 64'h0, 4'h9, 64'h1111_2222_3333_4444, 2);
        add_entry(1, 10'h105, FULL, 64'h0f1e_2d3c_4b5a_6978, 4'h0, 64'h0, 0);
        add_entry(0, 10'h105, 64'h0, 64'h0, 4'ha, 64'h0f1e_2d3c_4b5a_6978, 0);
        add_entry(0, 10'h005, 64'h0, 64'h0, 4'hb, 64'h1111_2222_3333_4444, 0);
        add_entry(0, 10'h305, 64'h0, 64'h0, 4'hc, 64'hdddd_eeee_ffff_0000, 1);
        add_entry(1, 10'h3ff, FULL, 64'hfedc_ba98_7654_3210, 4'h0, 64'h0, 0);
        add_entry(0, 10'h3ff, 64'h0, 64'h0, 4'hd, 64'hfedc_ba98_7654_3210, 0);
        add_entry(1, 10'h3ff, 64'h0000_ffff_ffff_0000, 64'h1111_2222_3333_4444,
                  4'h0, 64'h0, 0);  // middle bits straddle the columns
        add_entry(0, 10'h3ff, 64'h0, 64'h0, 4'he, 64'hfedc_2222_3333_3210, 0);
        add_entry(0, 10'h010, 64'h0, 64'h0, 4'hf, 64'h0123_4567_89ab_cdef, 0);
        add_entry(0, 10'h020, 64'h0, 64'h0, 4'h0, 64'h1200_5600_0a0c_d0f0, 0);  // tag wraps
    endtask

    // one request strobe, 1 ns after the edge
    task automatic drive_entry(input int idx);
        entry_t   e;
        pending_t p;
        e = stim[idx];
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req       = '{e.write, e.addr, e.mask, e.wdata, e.tag};
        if (!e.write) begin
            p = '{idx, e.tag, e.exp, cycle_cnt + LATENCY};
            exp_q.push_back(p);
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        req       = '0;
    endtask

    // compare one response with the oldest outstanding read
    task automatic check_response();
        pending_t p;
        bit       ok;
        assert (exp_q.size() > 0) else begin
            $display("response with tag %h arrived while no read was outstanding", rsp.tag);
            error_cnt++;
        end
        if (exp_q.size() > 0) begin
            p  = exp_q.pop_front();
            ok = 1'b1;
            assert (rsp.tag === p.tag) else begin
                $display("CHECK FAILED rsp.tag exp=%h got=%h", p.tag, rsp.tag);
                ok = 1'b0;
            end
            assert (rsp.rdata === p.rdata) else begin
                $display("CHECK FAILED rsp.rdata exp=%h got=%h", p.rdata, rsp.rdata);
                ok = 1'b0;
            end
            assert (cycle_cnt == p.due) else begin
                $display("response for entry %0d came in cycle %0d instead of cycle %0d",
                         p.entry, cycle_cnt, p.due);
                ok = 1'b0;
            end
            test_cnt++;
            if (ok) begin
                pass_cnt++;
                $display("test %0d entry %0d addr %h tag %h ok", test_cnt, p.entry,
                         stim[p.entry].addr, p.tag);
            end else begin
                error_cnt++;
                $display("test %0d entry %0d addr %h tag %h failed", test_cnt, p.entry,
                         stim[p.entry].addr, p.tag);
            end
        end
    endtask

    // outputs sampled mid-cycle, clear of the edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && rsp_valid !== 1'b0) begin
            check_response();
        end
    end

    initial begin
        int total;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        load_table();
        total = 0;
        foreach (stim[i]) begin
            total += 1 + stim[i].gap;
        end
        cycle_limit = RST_CYCLES + total + LATENCY + MARGIN;

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (4) drive_idle();  // quiet bus, no response allowed
        for (int i = 0; i < stim.size(); i++) begin
            drive_entry(i);
            repeat (stim[i].gap) drive_idle();
        end
        drive_idle();

        while (exp_q.size() > 0) @(posedge clk);
        repeat (3) @(posedge clk);  // catch stray responses

        $display("tests %0d, passed %0d, errors %0d, reads sent %0d",
                 test_cnt, pass_cnt, error_cnt, read_cnt);
        if (error_cnt == 0 && pass_cnt == read_cnt) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/spram_subsys.sv ====
// request stage, tiled SRAM and response stage in one chain
// 3 cycle read latency with in-order responses and no response for writes
`timescale 1ns/10ps
`default_nettype none

module spram_subsys #(
    parameter int MACRO_AW = 8,   // macro address width, passed down
    parameter int MACRO_DW = 32   // macro word width, passed down
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,  // single-cycle request strobe
    input  spram_pkg::mem_req_t  req,
    output logic                 rsp_valid,  // single-cycle response strobe
    output spram_pkg::mem_rsp_t  rsp
);

    import spram_pkg::*;

    logic              ce;        // request stage to sram
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wmask;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] dout;      // sram to response stage
    logic              rd_issue;  // request stage to response stage
    logic [TAG_W-1:0]  rd_tag;

    mem_req_stage req_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .ce        (ce),
        .we        (we),
        .addr      (addr),
        .wmask     (wmask),
        .wdata     (wdata),
        .rd_issue  (rd_issue),
        .rd_tag    (rd_tag)
    );

    spram #(
        .MACRO_AW (MACRO_AW),
        .MACRO_DW (MACRO_DW)
    ) spram_i (
        .clk   (clk),
        .ce    (ce),
        .we    (we),
        .addr  (addr),
        .wmask (wmask),
        .din   (wdata),
        .dout  (dout)
    );

    mem_rsp_stage rsp_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_issue  (rd_issue),
        .rd_tag    (rd_tag),
        .rdata     (dout),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== source/mem_rsp_stage.sv ====
// rsp_valid rises two cycles after rd_issue
// writes never reach here, so every rd_issue yields exactly one response
`timescale 1ns/10ps
`default_nettype none

module mem_rsp_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rd_issue,   // read issued to macro
    input  logic [spram_pkg::TAG_W-1:0]   rd_tag,     // tag of that read
    input  logic [spram_pkg::DATA_W-1:0]  rdata,      // macro data, next cycle
    output logic                          rsp_valid,  // single-cycle strobe
    output spram_pkg::mem_rsp_t           rsp         // data and tag
);

    import spram_pkg::*;

    logic             issue_q;  // read data on rdata this cycle
    logic [TAG_W-1:0] tag_q;    // tag aligned with rdata

    // control pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_q   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            issue_q   <= rd_issue;
            rsp_valid <= issue_q;
        end
    end

    // tag waits one cycle for the macro data
    always_ff @(posedge clk) begin
        if (rd_issue) begin
            tag_q <= rd_tag;
        end
        if (issue_q) begin
            rsp.rdata <= rdata;  // capture together with tag
            rsp.tag   <= tag_q;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_req_stage.sv ====
// one register stage from req_valid to ce
// no back-pressure so a new request may arrive every cycle
`timescale 1ns/10ps
`default_nettype none

module mem_req_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,  // single-cycle strobe
    input  spram_pkg::mem_req_t           req,        // request payload
    output logic                          ce,         // macro chip enable
    output logic                          we,         // macro write enable
    output logic [spram_pkg::ADDR_W-1:0]  addr,
    output logic [spram_pkg::DATA_W-1:0]  wmask,
    output logic [spram_pkg::DATA_W-1:0]  wdata,
    output logic                          rd_issue,   // read sent to macro
    output logic [spram_pkg::TAG_W-1:0]   rd_tag      // tag of that read
);

    import spram_pkg::*;

    logic     valid_q;  // registered strobe
    mem_req_t req_q;    // registered payload

    // strobe pipe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // payload only loads with a strobe
    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
    end

    // macro side
    assign ce    = valid_q;
    assign we    = valid_q && req_q.write;  // stale write bit masked off
    assign addr  = req_q.addr;
    assign wmask = req_q.wmask;
    assign wdata = req_q.wdata;

    // read bookkeeping for the response stage
    assign rd_issue = valid_q && !req_q.write;
    assign rd_tag   = req_q.tag;

endmodule

`default_nettype wire

// ==== source/spram.sv ====
// upper address bits pick a bank row and the word splits into macro columns
// needs MACRO_AW <= ADDR_W; columns past DATA_W are tied off and never read
`timescale 1ns/10ps
`default_nettype none

module spram #(
    parameter int MACRO_AW = 8,   // macro address width
    parameter int MACRO_DW = 32   // macro word width
) (
    input  logic                          clk,
    input  logic                          ce,     // chip enable
    input  logic                          we,     // write enable
    input  logic [spram_pkg::ADDR_W-1:0]  addr,   // word address
    input  logic [spram_pkg::DATA_W-1:0]  wmask,  // per bit write mask
    input  logic [spram_pkg::DATA_W-1:0]  din,    // write data
    output logic [spram_pkg::DATA_W-1:0]  dout    // read data of last read bank
);

    import spram_pkg::*;

    localparam bit MULTI_BANK = ADDR_W > MACRO_AW;
    localparam int BANK_W     = MULTI_BANK ? ADDR_W - MACRO_AW : 1;
    localparam int NUM_BANKS  = MULTI_BANK ? 2 ** (ADDR_W - MACRO_AW) : 1;
    localparam int NUM_COLS   = (DATA_W + MACRO_DW - 1) / MACRO_DW;  // round up
    localparam int PAD_W      = NUM_COLS * MACRO_DW;                 // padded word

    logic [BANK_W-1:0]   bank_idx;   // bank of current access
    logic [BANK_W-1:0]   bank_q;     // bank of last read, steers dout
    logic [MACRO_AW-1:0] macro_addr; // address inside a macro
    logic [PAD_W-1:0]    din_pad;    // write data padded to column grid
    logic [PAD_W-1:0]    wmask_pad;  // mask padded to column grid
    logic [PAD_W-1:0]    rd_sel;     // selected bank read word

    logic [NUM_BANKS-1:0][PAD_W-1:0] bank_rd;  // read words of every bank

    assign macro_addr = addr[MACRO_AW-1:0];

    // single bank when the macro covers all addresses
    generate
        if (MULTI_BANK) begin : g_banked
            assign bank_idx = addr[ADDR_W-1 -: BANK_W];
        end else begin : g_single
            assign bank_idx = '0;
        end
    endgenerate

    // pad bits of the write side stay zero
    assign din_pad[DATA_W-1:0]   = din;
    assign wmask_pad[DATA_W-1:0] = wmask;
    generate
        if (PAD_W > DATA_W) begin : g_pad
            assign din_pad[PAD_W-1:DATA_W]   = '0;
            assign wmask_pad[PAD_W-1:DATA_W] = '0;
        end
    endgenerate

    // macro read is synchronous, so remember which bank was read
    always_ff @(posedge clk) begin
        if (ce && !we) begin
            bank_q <= bank_idx;
        end
    end

    // macro grid with banks as rows and word slices as columns
    generate
        for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
            logic bank_hit;  // this row addressed
            logic bank_ce;
            logic bank_we;

            assign bank_hit = bank_idx == BANK_W'(b);
            assign bank_ce  = ce && bank_hit;
            assign bank_we  = we && bank_hit;

            for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
                ram_macro #(
                    .MACRO_AW (MACRO_AW),
                    .MACRO_DW (MACRO_DW)
                ) macro_i (
                    .clk       (clk),
                    .ce_in     (bank_ce),
                    .we_in     (bank_we),
                    .addr_in   (macro_addr),
                    .w_mask_in (wmask_pad[c*MACRO_DW +: MACRO_DW]),
                    .wd_in     (din_pad[c*MACRO_DW +: MACRO_DW]),
                    .rd_out    (bank_rd[b][c*MACRO_DW +: MACRO_DW])
                );
            end
        end
    endgenerate

    assign rd_sel = bank_rd[bank_q];    // registered index rather than live addr
    assign dout   = rd_sel[DATA_W-1:0]; // drop pad columns

endmodule

`default_nettype wire

// ==== source/ram_macro.sv ====
// behavioral single-port macro with synchronous read and bit-masked write
// contents are not reset; rd_out holds between reads
`timescale 1ns/10ps
`default_nettype none

module ram_macro #(
    parameter int MACRO_AW = 8,   // macro address width
    parameter int MACRO_DW = 32   // macro word width
) (
    input  logic                clk,
    input  logic                ce_in,      // chip enable
    input  logic                we_in,      // write enable, needs ce_in
    input  logic [MACRO_AW-1:0] addr_in,    // word address
    input  logic [MACRO_DW-1:0] w_mask_in,  // per bit write mask
    input  logic [MACRO_DW-1:0] wd_in,      // write data
    output logic [MACRO_DW-1:0] rd_out      // read data one cycle after ce
);

    localparam int DEPTH = 2 ** MACRO_AW;

    logic [MACRO_DW-1:0] mem [DEPTH];  // storage array
    logic [MACRO_DW-1:0] cur_word;     // addressed word, pre-merge

    assign cur_word = mem[addr_in];

    // only set bits of w_mask_in change
    always_ff @(posedge clk) begin
        if (ce_in && we_in) begin
            mem[addr_in] <= (cur_word & ~w_mask_in) | (wd_in & w_mask_in);
        end
    end

    // registered read port without read-during-write bypass
    always_ff @(posedge clk) begin
        if (ce_in && !we_in) begin
            rd_out <= cur_word;  // hold otherwise
        end
    end

endmodule

`default_nettype wire

// ==== source/spram_pkg.sv ====
// widths and request/response structs shared by the SRAM subsystem
`default_nettype none

package spram_pkg;

    parameter int DATA_W = 64;  // stored word width
    parameter int ADDR_W = 10;  // word address width
    parameter int TAG_W  = 4;   // read tag width

    // one request qualified by req_valid
    typedef struct packed {
        logic              write;  // 1 = write, 0 = read
        logic [ADDR_W-1:0] addr;   // word address
        logic [DATA_W-1:0] wmask;  // set bit means write this bit
        logic [DATA_W-1:0] wdata;  // write payload
        logic [TAG_W-1:0]  tag;    // returned with read data
    } mem_req_t;

    // read response qualified by rsp_valid
    typedef struct packed {
        logic [DATA_W-1:0] rdata;  // word read from the array
        logic [TAG_W-1:0]  tag;    // tag of the matching read
    } mem_rsp_t;

endpackage

`default_nettype wire
